// ==== Bender.yml ====
package:
  name: lane_top

sources:
  - files:
      - logic/lane_pkg.sv
      - logic/lane_control.sv
      - logic/lane_engine.sv
      - logic/lane_memory_arbiter.sv
      - logic/lane_memory_router.sv
      - logic/lane_top.sv
  - target: simulation
    files:
      - testbench/lane_tb.sv

// ==== lane_top.f ====
logic/lane_pkg.sv
logic/lane_control.sv
logic/lane_engine.sv
logic/lane_memory_arbiter.sv
logic/lane_memory_router.sv
logic/lane_top.sv
testbench/lane_tb.sv

// ==== logic/lane_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_control (
    input  logic                                             ap_clk,
    input  logic                                             areset_lane_template,
    input  logic                                             desc_req_i,
    input  lane_pkg::lane_descriptor_t                       desc_i,
    output logic                                             desc_ack_o,
    input  logic                                             out_req_i,
    input  logic                                             out_ack_i,
    input  logic                                             mem_req_i,
    input  logic                                             mem_ack_i,
    output lane_pkg::engine_cfg_t [lane_pkg::NUM_ENGINES-1:0] engine_cfg_o,
    output logic                                             done_o
);

    lane_pkg::lane_descriptor_t   desc_q;
    logic [lane_pkg::COUNT_W-1:0] out_count_q;
    logic                         out_ack_q;
    logic                         armed_q;
    logic                         mem_open_q;
    logic                         desc_accept;
    logic                         out_done;

    // Accept while req is high and ack not yet given
    assign desc_accept = desc_req_i & ~desc_ack_o;
    // One completed output transfer per rising ack
    assign out_done     = out_req_i & out_ack_i & ~out_ack_q;
    // Config held as a level until the next descriptor
    assign engine_cfg_o = desc_q.cfg;

    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            desc_q      <= '0;
            desc_ack_o  <= 1'b0;
            out_count_q <= '0;
            out_ack_q   <= 1'b0;
            armed_q     <= 1'b0;
            mem_open_q  <= 1'b0;
            done_o      <= 1'b0;
        end else begin
            // Ack mirrors req one cycle late
            desc_ack_o <= desc_req_i;
            out_ack_q  <= out_ack_i;
            // Request seen by memory but not yet acked
            if (mem_ack_i) begin
                mem_open_q <= 1'b0;
            end else if (mem_req_i) begin
                mem_open_q <= 1'b1;
            end
            if (desc_accept) begin
                desc_q      <= desc_i;
                out_count_q <= '0;
                armed_q     <= 1'b1;
                done_o      <= 1'b0;
            end else begin
                if (out_done) begin
                    out_count_q <= out_count_q + 1'b1;
                end
                // Sticky until the next descriptor
                if (armed_q && out_count_q == desc_q.num_packets && !mem_open_q && !mem_req_i) begin
                    done_o <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/lane_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_engine #(
    parameter int ENGINE_ID = 0
) (
    input  logic                    ap_clk,
    input  logic                    areset_lane_template,
    input  lane_pkg::engine_cfg_t   cfg_i,
    // Upstream packet channel
    input  logic                    in_req_i,
    input  lane_pkg::lane_packet_t  in_packet_i,
    output logic                    in_ack_o,
    // Downstream packet channel
    output logic                    out_req_o,
    output lane_pkg::lane_packet_t  out_packet_o,
    input  logic                    out_ack_i,
    // Memory request toward the arbiter
    output logic                    mem_req_o,
    output lane_pkg::mem_request_t  mem_request_o,
    input  logic                    mem_ack_i,
    // Memory response from the router
    input  logic                    mem_rsp_req_i,
    input  lane_pkg::mem_response_t mem_response_i,
    output logic                    mem_rsp_ack_o
);

    lane_pkg::engine_state_t       state_q;
    lane_pkg::lane_packet_t        pkt_q;
    logic [lane_pkg::DATA_W-1:0]   operand_ext;
    logic [lane_pkg::ADDR_W-1:0]   read_addr;

    assign operand_ext = {{(lane_pkg::DATA_W - lane_pkg::OPERAND_W){1'b0}}, cfg_i.operand};
    // Address is data plus operand, wraps at 2^32
    assign read_addr   = pkt_q.data + operand_ext;

    // Held packet is stable for the whole output transfer
    assign out_packet_o            = pkt_q;
    assign mem_request_o.addr      = read_addr;
    assign mem_request_o.engine_id = ENGINE_ID[lane_pkg::ENGINE_ID_W-1:0];

    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            state_q       <= lane_pkg::ENG_IDLE;
            in_ack_o      <= 1'b0;
            out_req_o     <= 1'b0;
            mem_req_o     <= 1'b0;
            mem_rsp_ack_o <= 1'b0;
        end else begin
            case (state_q)
                // --------------------
                // Input side
                // --------------------
                lane_pkg::ENG_IDLE: begin
                    if (in_req_i) begin
                        pkt_q    <= in_packet_i;
                        in_ack_o <= 1'b1;
                        state_q  <= lane_pkg::ENG_RELEASE_IN;
                    end
                end
                lane_pkg::ENG_RELEASE_IN: begin
                    // Upstream dropped req, close the handshake and apply op
                    if (!in_req_i) begin
                        in_ack_o <= 1'b0;
                        case (cfg_i.op)
                            lane_pkg::OP_READ: begin
                                mem_req_o <= 1'b1;
                                state_q   <= lane_pkg::ENG_MEM_REQ;
                            end
                            lane_pkg::OP_ADD: begin
                                pkt_q.data <= pkt_q.data + operand_ext;
                                state_q    <= lane_pkg::ENG_SEND;
                            end
                            default: begin
                                state_q <= lane_pkg::ENG_SEND;
                            end
                        endcase
                    end
                end
                // --------------------
                // Memory side
                // --------------------
                lane_pkg::ENG_MEM_REQ: begin
                    // Full four phases before waiting on the response
                    if (mem_req_o && mem_ack_i) begin
                        mem_req_o <= 1'b0;
                    end else if (!mem_req_o && !mem_ack_i) begin
                        state_q <= lane_pkg::ENG_MEM_WAIT;
                    end
                end
                lane_pkg::ENG_MEM_WAIT: begin
                    if (mem_rsp_req_i && !mem_rsp_ack_o) begin
                        // Returned word replaces the data, tag untouched
                        pkt_q.data    <= mem_response_i.data;
                        mem_rsp_ack_o <= 1'b1;
                    end else if (!mem_rsp_req_i && mem_rsp_ack_o) begin
                        mem_rsp_ack_o <= 1'b0;
                        state_q       <= lane_pkg::ENG_SEND;
                    end
                end
                // --------------------
                // Output side
                // --------------------
                lane_pkg::ENG_SEND: begin
                    // Downstream ack must be low before a new transfer
                    if (!out_ack_i) begin
                        out_req_o <= 1'b1;
                        state_q   <= lane_pkg::ENG_SEND_WAIT;
                    end
                end
                lane_pkg::ENG_SEND_WAIT: begin
                    // Packet held until ack has risen and fallen again
                    if (out_req_o && out_ack_i) begin
                        out_req_o <= 1'b0;
                    end else if (!out_req_o && !out_ack_i) begin
                        state_q <= lane_pkg::ENG_IDLE;
                    end
                end
                default: begin
                    state_q <= lane_pkg::ENG_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/lane_memory_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_memory_arbiter (
    input  logic                                              ap_clk,
    input  logic                                              areset_lane_template,
    input  logic [lane_pkg::NUM_ENGINES-1:0]                  eng_req_i,
    input  lane_pkg::mem_request_t [lane_pkg::NUM_ENGINES-1:0] eng_request_i,
    output logic [lane_pkg::NUM_ENGINES-1:0]                  eng_ack_o,
    output logic                                              mem_req_o,
    output lane_pkg::mem_request_t                            mem_request_o,
    input  logic                                              mem_ack_i
);

    logic                             busy_q;
    logic [lane_pkg::ENGINE_ID_W-1:0] grant_q;
    logic                             pick_valid;
    logic [lane_pkg::ENGINE_ID_W-1:0] pick_idx;

    // --------------------
    // Round-robin pick
    // --------------------
    // Search starts just after the last granted engine
    always_comb begin
        int idx;
        pick_valid = 1'b0;
        pick_idx   = grant_q;
        for (int k = 1; k <= lane_pkg::NUM_ENGINES; k++) begin
            idx = (int'(grant_q) + k) % lane_pkg::NUM_ENGINES;
            if (!pick_valid && eng_req_i[idx]) begin
                pick_valid = 1'b1;
                pick_idx   = idx[lane_pkg::ENGINE_ID_W-1:0];
            end
        end
    end

    // Granted engine's payload goes straight out
    assign mem_request_o = eng_request_i[grant_q];

    // Memory ack returns to the granted engine only
    always_comb begin
        eng_ack_o          = '0;
        eng_ack_o[grant_q] = busy_q & mem_ack_i;
    end

    // --------------------
    // Locked grant
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            busy_q    <= 1'b0;
            grant_q   <= '0;
            mem_req_o <= 1'b0;
        end else if (!busy_q) begin
            if (pick_valid) begin
                busy_q  <= 1'b1;
                grant_q <= pick_idx;
            end
        end else begin
            // Memory req follows the engine req one cycle late
            mem_req_o <= eng_req_i[grant_q];
            // Release only after both sides are back to zero
            if (!eng_req_i[grant_q] && !mem_req_o && !mem_ack_i) begin
                busy_q <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/lane_memory_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_memory_router (
    input  logic                                               ap_clk,
    input  logic                                               areset_lane_template,
    input  logic                                               mem_rsp_req_i,
    input  lane_pkg::mem_response_t                            mem_response_i,
    output logic                                               mem_rsp_ack_o,
    output logic [lane_pkg::NUM_ENGINES-1:0]                   eng_rsp_req_o,
    output lane_pkg::mem_response_t [lane_pkg::NUM_ENGINES-1:0] eng_response_o,
    input  logic [lane_pkg::NUM_ENGINES-1:0]                   eng_rsp_ack_i
);

    logic                             busy_q;
    logic                             rsp_req_q;
    logic [lane_pkg::ENGINE_ID_W-1:0] sel_q;
    lane_pkg::mem_response_t          rsp_q;

    // Same registered word to every engine, req only to the selected one
    for (genvar g = 0; g < lane_pkg::NUM_ENGINES; g++) begin : g_fanout
        assign eng_rsp_req_o[g]  = rsp_req_q & (sel_q == g);
        assign eng_response_o[g] = rsp_q;
    end

    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            busy_q        <= 1'b0;
            rsp_req_q     <= 1'b0;
            sel_q         <= '0;
            mem_rsp_ack_o <= 1'b0;
        end else if (!busy_q) begin
            // New response only with the external channel idle
            if (mem_rsp_req_i && !mem_rsp_ack_o) begin
                busy_q    <= 1'b1;
                rsp_req_q <= 1'b1;
                sel_q     <= mem_response_i.engine_id;
                rsp_q     <= mem_response_i;
            end
        end else begin
            // External ack trails the engine ack by one cycle
            mem_rsp_ack_o <= eng_rsp_ack_i[sel_q];
            if (!mem_rsp_req_i) begin
                rsp_req_q <= 1'b0;
            end
            // Engine side fully released
            if (!mem_rsp_req_i && !rsp_req_q && !eng_rsp_ack_i[sel_q]) begin
                busy_q <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/lane_pkg.sv ====
`default_nettype none

package lane_pkg;

    // --------------------
    // Lane sizing
    // --------------------
    localparam int NUM_ENGINES = 3;
    localparam int DATA_W      = 32;
    localparam int ADDR_W      = 32;
    localparam int TAG_W       = 8;
    // Operand is zero-extended to DATA_W before use
    localparam int OPERAND_W   = 16;
    localparam int ENGINE_ID_W = 2;
    localparam int COUNT_W     = 16;

    // --------------------
    // Encodings
    // --------------------
    typedef enum logic [1:0] {
        OP_PASS = 2'd0,
        OP_ADD  = 2'd1,
        OP_READ = 2'd2
    } engine_op_t;

    typedef enum logic [2:0] {
        ENG_IDLE       = 3'd0,
        ENG_RELEASE_IN = 3'd1,
        ENG_MEM_REQ    = 3'd2,
        ENG_MEM_WAIT   = 3'd3,
        ENG_SEND       = 3'd4,
        ENG_SEND_WAIT  = 3'd5
    } engine_state_t;

    // --------------------
    // Channel payloads
    // --------------------
    // Per-engine setup, 18 bits
    typedef struct packed {
        engine_op_t           op;
        logic [OPERAND_W-1:0] operand;
    } engine_cfg_t;

    // Engine 0 config sits in cfg[0]
    typedef struct packed {
        engine_cfg_t [NUM_ENGINES-1:0] cfg;
        logic [COUNT_W-1:0]            num_packets;
    } lane_descriptor_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [TAG_W-1:0]  tag;
    } lane_packet_t;

    typedef struct packed {
        logic [ADDR_W-1:0]      addr;
        logic [ENGINE_ID_W-1:0] engine_id;
    } mem_request_t;

    // engine_id selects the receiving engine
    typedef struct packed {
        logic [DATA_W-1:0]      data;
        logic [ENGINE_ID_W-1:0] engine_id;
    } mem_response_t;

endpackage

`default_nettype wire

// ==== logic/lane_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_top (
    input  logic                       ap_clk,
    input  logic                       areset_lane_template,
    input  logic                       desc_req_i,
    input  lane_pkg::lane_descriptor_t desc_i,
    output logic                       desc_ack_o,
    input  logic                       in_req_i,
    input  lane_pkg::lane_packet_t     in_packet_i,
    output logic                       in_ack_o,
    output logic                       out_req_o,
    output lane_pkg::lane_packet_t     out_packet_o,
    input  logic                       out_ack_i,
    output logic                       mem_req_o,
    output lane_pkg::mem_request_t     mem_request_o,
    input  logic                       mem_ack_i,
    input  logic                       mem_rsp_req_i,
    input  lane_pkg::mem_response_t    mem_response_i,
    output logic                       mem_rsp_ack_o,
    output logic                       done_o
);

    // --------------------
    // Chain wires
    // --------------------
    // Slot k is the input of engine k, last slot is the lane output
    logic [lane_pkg::NUM_ENGINES:0]                     chain_req;
    logic [lane_pkg::NUM_ENGINES:0]                     chain_ack;
    lane_pkg::lane_packet_t [lane_pkg::NUM_ENGINES:0]    chain_pkt;
    lane_pkg::engine_cfg_t [lane_pkg::NUM_ENGINES-1:0]   engine_cfg;
    // Engine memory channels
    logic [lane_pkg::NUM_ENGINES-1:0]                   eng_mem_req;
    logic [lane_pkg::NUM_ENGINES-1:0]                   eng_mem_ack;
    lane_pkg::mem_request_t [lane_pkg::NUM_ENGINES-1:0]  eng_mem_request;
    logic [lane_pkg::NUM_ENGINES-1:0]                   eng_rsp_req;
    logic [lane_pkg::NUM_ENGINES-1:0]                   eng_rsp_ack;
    lane_pkg::mem_response_t [lane_pkg::NUM_ENGINES-1:0] eng_response;

    assign chain_req[0]                     = in_req_i;
    assign chain_pkt[0]                     = in_packet_i;
    assign in_ack_o                         = chain_ack[0];
    assign out_req_o                        = chain_req[lane_pkg::NUM_ENGINES];
    assign out_packet_o                     = chain_pkt[lane_pkg::NUM_ENGINES];
    assign chain_ack[lane_pkg::NUM_ENGINES] = out_ack_i;

    lane_control u_control (
        .ap_clk               (ap_clk),
        .areset_lane_template (areset_lane_template),
        .desc_req_i           (desc_req_i),
        .desc_i               (desc_i),
        .desc_ack_o           (desc_ack_o),
        .out_req_i            (out_req_o),
        .out_ack_i            (out_ack_i),
        .mem_req_i            (mem_req_o),
        .mem_ack_i            (mem_ack_i),
        .engine_cfg_o         (engine_cfg),
        .done_o               (done_o)
    );

    // in -> [0] -> [1] -> [2] -> out
    for (genvar g = 0; g < lane_pkg::NUM_ENGINES; g++) begin : g_engine
        lane_engine #(
            .ENGINE_ID (g)
        ) u_engine (
            .ap_clk               (ap_clk),
            .areset_lane_template (areset_lane_template),
            .cfg_i                (engine_cfg[g]),
            .in_req_i             (chain_req[g]),
            .in_packet_i          (chain_pkt[g]),
            .in_ack_o             (chain_ack[g]),
            .out_req_o            (chain_req[g+1]),
            .out_packet_o         (chain_pkt[g+1]),
            .out_ack_i            (chain_ack[g+1]),
            .mem_req_o            (eng_mem_req[g]),
            .mem_request_o        (eng_mem_request[g]),
            .mem_ack_i            (eng_mem_ack[g]),
            .mem_rsp_req_i        (eng_rsp_req[g]),
            .mem_response_i       (eng_response[g]),
            .mem_rsp_ack_o        (eng_rsp_ack[g])
        );
    end

    lane_memory_arbiter u_arbiter (
        .ap_clk               (ap_clk),
        .areset_lane_template (areset_lane_template),
        .eng_req_i            (eng_mem_req),
        .eng_request_i        (eng_mem_request),
        .eng_ack_o            (eng_mem_ack),
        .mem_req_o            (mem_req_o),
        .mem_request_o        (mem_request_o),
        .mem_ack_i            (mem_ack_i)
    );

    lane_memory_router u_router (
        .ap_clk               (ap_clk),
        .areset_lane_template (areset_lane_template),
        .mem_rsp_req_i        (mem_rsp_req_i),
        .mem_response_i       (mem_response_i),
        .mem_rsp_ack_o        (mem_rsp_ack_o),
        .eng_rsp_req_o        (eng_rsp_req),
        .eng_response_o       (eng_response),
        .eng_rsp_ack_i        (eng_rsp_ack)
    );

endmodule

`default_nettype wire

// ==== testbench/lane_cases.txt ====
# D op0 operand0 op1 operand1 op2 operand2 num_packets  (op 0 pass, 1 add, 2 read; operands hex)
# P data tag expected_data  (hex)
D 1 0010 1 0200 1 3000 4
P 00000000 01 00003210
P 12345678 02 12348888
P fffff000 03 00002210
P 7fffffff 04 8000320f
D 0 0000 2 0004 0 0000 3
P 00001000 10 5a5ab5a1
P 5a5aa5a1 11 00000000
P 00000000 12 5a5aa5a1
D 1 0100 2 0020 1 0003 6
P 00000000 20 5a5aa488
P 00000010 21 5a5aa498
P 0000ff00 22 5a5ba588
P abcdef00 23 f1975588
P fffffee0 24 5a5aa5a8
P 01020304 25 5b58a184
D 2 0000 1 0005 2 0008 4
P 00000000 30 00000017
P 5a5aa5a5 31 5a5aa5a8
P 12345678 32 1234564f
P ffffffff 33 ffffffc2

// ==== testbench/lane_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_tb;

    logic                       ap_clk = 1'b0;
    logic                       areset_lane_template;
    logic                       desc_req_i;
    lane_pkg::lane_descriptor_t desc_i;
    logic                       desc_ack_o;
    logic                       in_req_i;
    lane_pkg::lane_packet_t     in_packet_i;
    logic                       in_ack_o;
    logic                       out_req_o;
    lane_pkg::lane_packet_t     out_packet_o;
    logic                       out_ack_i;
    logic                       mem_req_o;
    lane_pkg::mem_request_t     mem_request_o;
    logic                       mem_ack_i;
    logic                       mem_rsp_req_i;
    lane_pkg::mem_response_t    mem_response_i;
    logic                       mem_rsp_ack_o;
    logic                       done_o;

    // Cases from the data file
    lane_pkg::lane_descriptor_t d_list [16];
    int                         d_first [16];
    int                         d_plines [16];
    int                         d_num = 0;
    logic [31:0]                p_data [64];
    logic [7:0]                 p_tag [64];
    logic [31:0]                p_exp [64];
    // Expected read address per packet and engine
    logic [31:0]                exp_addr [64][3];
    int                         p_num = 0;
    // Descriptor under test, shared with the memory model
    lane_pkg::lane_descriptor_t cur_desc = '0;
    int                         cur_base = 0;
    int                         cur_count = 0;
    int                         mem_ptr [3];
    logic [31:0]                lfsr_q = 32'hfdb4_5282;
    int                         cycle_q = 0;
    int                         cycle_limit = 1000;

    lane_top UUT (
        .ap_clk               (ap_clk),
        .areset_lane_template (areset_lane_template),
        .desc_req_i           (desc_req_i),
        .desc_i               (desc_i),
        .desc_ack_o           (desc_ack_o),
        .in_req_i             (in_req_i),
        .in_packet_i          (in_packet_i),
        .in_ack_o             (in_ack_o),
        .out_req_o            (out_req_o),
        .out_packet_o         (out_packet_o),
        .out_ack_i            (out_ack_i),
        .mem_req_o            (mem_req_o),
        .mem_request_o        (mem_request_o),
        .mem_ack_i            (mem_ack_i),
        .mem_rsp_req_i        (mem_rsp_req_i),
        .mem_response_i       (mem_response_i),
        .mem_rsp_ack_o        (mem_rsp_ack_o),
        .done_o               (done_o)
    );

    // 8 ns period
    always #4 ap_clk = ~ap_clk;

    // --------------------
    // Helpers
    // --------------------
    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            fail_run($sformatf("ERROR: %s got 0x%0h expected 0x%0h", name, got, expected));
        end
    endtask

    // Memory content rule
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        mem_word = addr ^ 32'h5a5a_a5a5;
    endfunction

    // Galois LFSR, one step per bit taken
    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            r = (r << 1) | int'(lfsr_q[0]);
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
        end
        return r;
    endfunction

    // 0 to 7 cycles
    task automatic random_wait();
        int n;
        n = rand_bits(3);
        repeat (n) @(posedge ap_clk);
    endtask

    // Hard cycle limit
    always @(posedge ap_clk) begin
        cycle_q = cycle_q + 1;
        if (cycle_q >= cycle_limit) begin
            fail_run($sformatf("Timeout: no finish within %0d cycles", cycle_limit));
        end
    end

    // --------------------
    // Cases file
    // --------------------
    task automatic read_cases();
        int                         fd;
        int                         code;
        string                      line;
        int                         op [3];
        logic [15:0]                opnd [3];
        int                         count;
        logic [31:0]                data;
        logic [31:0]                expected;
        logic [31:0]                d;
        logic [7:0]                 tag;
        lane_pkg::lane_descriptor_t desc;
        fd = $fopen("testbench/lane_cases.txt", "r");
        if (fd == 0) begin
            fail_run("Cannot open the cases file testbench/lane_cases.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            // Blank lines and comments
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            code = $sscanf(line, "D %d %h %d %h %d %h %d", op[0], opnd[0], op[1], opnd[1],
                           op[2], opnd[2], count);
            if (code == 7) begin
                for (int e = 0; e < 3; e++) begin
                    desc.cfg[e].op      = lane_pkg::engine_op_t'(op[e][1:0]);
                    desc.cfg[e].operand = opnd[e];
                end
                desc.num_packets = count[15:0];
                d_list[d_num]    = desc;
                d_first[d_num]   = p_num;
                d_plines[d_num]  = 0;
                d_num++;
                continue;
            end
            code = $sscanf(line, "P %h %h %h", data, tag, expected);
            if (code != 3 || d_num == 0) begin
                fail_run("Cases file has a line that is not a valid D or P line");
            end
            // Walk the packet through the engine rules
            d = data;
            for (int e = 0; e < 3; e++) begin
                case (desc.cfg[e].op)
                    lane_pkg::OP_ADD: d = d + {16'h0, desc.cfg[e].operand};
                    lane_pkg::OP_READ: begin
                        exp_addr[p_num][e] = d + {16'h0, desc.cfg[e].operand};
                        d = mem_word(exp_addr[p_num][e]);
                    end
                    default: d = d;
                endcase
            end
            check_value("cases file expected data", expected, d);
            p_data[p_num] = data;
            p_tag[p_num]  = tag;
            p_exp[p_num]  = expected;
            p_num++;
            d_plines[d_num-1]++;
        end
        $fclose(fd);
        for (int i = 0; i < d_num; i++) begin
            check_value("cases file packets per descriptor", d_plines[i],
                        d_list[i].num_packets);
        end
    endtask

    // --------------------
    // Channel drivers
    // --------------------
    task automatic send_descriptor(input lane_pkg::lane_descriptor_t desc);
        @(posedge ap_clk);
        desc_i     <= desc;
        desc_req_i <= 1'b1;
        do @(posedge ap_clk); while (!desc_ack_o);
        desc_req_i <= 1'b0;
        do @(posedge ap_clk); while (desc_ack_o);
    endtask

    task automatic drive_inputs();
        lane_pkg::lane_packet_t pkt;
        for (int p = cur_base; p < cur_base + cur_count; p++) begin
            pkt.data = p_data[p];
            pkt.tag  = p_tag[p];
            @(posedge ap_clk);
            in_packet_i <= pkt;
            in_req_i    <= 1'b1;
            do @(posedge ap_clk); while (!in_ack_o);
            in_req_i <= 1'b0;
            do @(posedge ap_clk); while (in_ack_o);
        end
    endtask

    // Random ack delay gives back-pressure
    task automatic collect_outputs();
        for (int p = cur_base; p < cur_base + cur_count; p++) begin
            do @(posedge ap_clk); while (!out_req_o);
            check_value("done_o", done_o, 1'b0);
            check_value("out_packet_o.data", out_packet_o.data, p_exp[p]);
            check_value("out_packet_o.tag", out_packet_o.tag, p_tag[p]);
            random_wait();
            out_ack_i <= 1'b1;
            do @(posedge ap_clk); while (out_req_o);
            out_ack_i <= 1'b0;
        end
    endtask

    // --------------------
    // Memory model
    // --------------------
    initial begin : memory_model
        lane_pkg::mem_request_t req;
        int                     e;
        forever begin
            do @(posedge ap_clk); while (!mem_req_o);
            req = mem_request_o;
            e   = int'(req.engine_id);
            if (e >= 3 || cur_desc.cfg[e].op != lane_pkg::OP_READ) begin
                fail_run("Memory request came from an engine that is not set to read");
            end
            if (mem_ptr[e] >= cur_count) begin
                fail_run("Engine issued more memory requests than packets");
            end
            check_value("mem_request_o.addr", req.addr, exp_addr[cur_base + mem_ptr[e]][e]);
            mem_ptr[e]++;
            random_wait();
            mem_ack_i <= 1'b1;
            do @(posedge ap_clk); while (mem_req_o);
            mem_ack_i <= 1'b0;
            // Response back to the same engine
            random_wait();
            mem_response_i.data      <= mem_word(req.addr);
            mem_response_i.engine_id <= req.engine_id;
            mem_rsp_req_i            <= 1'b1;
            do @(posedge ap_clk); while (!mem_rsp_ack_o);
            mem_rsp_req_i <= 1'b0;
            do @(posedge ap_clk); while (mem_rsp_ack_o);
        end
    end

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        areset_lane_template = 1'b1;
        desc_req_i           = 1'b0;
        desc_i               = '0;
        in_req_i             = 1'b0;
        in_packet_i          = '0;
        out_ack_i            = 1'b0;
        mem_ack_i            = 1'b0;
        mem_rsp_req_i        = 1'b0;
        mem_response_i       = '0;
        for (int e = 0; e < 3; e++) begin
            mem_ptr[e] = 0;
        end
        read_cases();
        cycle_limit = 1000 + 200 * p_num;
        repeat (10) @(posedge ap_clk);
        areset_lane_template <= 1'b0;
        // All control outputs quiet before any descriptor
        repeat (5) begin
            @(posedge ap_clk);
            check_value("in_ack_o", in_ack_o, 1'b0);
            check_value("out_req_o", out_req_o, 1'b0);
            check_value("mem_req_o", mem_req_o, 1'b0);
            check_value("mem_rsp_ack_o", mem_rsp_ack_o, 1'b0);
            check_value("desc_ack_o", desc_ack_o, 1'b0);
            check_value("done_o", done_o, 1'b0);
        end
        for (int i = 0; i < d_num; i++) begin
            cur_desc  = d_list[i];
            cur_base  = d_first[i];
            cur_count = d_list[i].num_packets;
            for (int e = 0; e < 3; e++) begin
                mem_ptr[e] = 0;
            end
            send_descriptor(d_list[i]);
            // Previous done must be cleared
            check_value("done_o", done_o, 1'b0);
            fork
                drive_inputs();
                collect_outputs();
            join
            do @(posedge ap_clk); while (!done_o);
            for (int e = 0; e < 3; e++) begin
                if (cur_desc.cfg[e].op == lane_pkg::OP_READ) begin
                    check_value("memory requests per engine", mem_ptr[e], cur_count);
                end
            end
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
